//--- Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - .
    files:
      - rtl/exu_pkg.sv
      - rtl/exu_hilo.sv
      - rtl/exu_alu.sv
      - rtl/exu_div.sv
      - rtl/exu_top.sv
      - target: test
        files:
          - dv/exu_tb.sv

//--- all.f
+incdir+.
rtl/exu_pkg.sv
rtl/exu_hilo.sv
rtl/exu_alu.sv
rtl/exu_div.sv
rtl/exu_top.sv
dv/exu_tb.sv

//--- dv/exu_tb.sv
/*
 * execute unit testbench: random ops checked against a reference model,
 * HI/LO read back through MFHI/MFLO, divide latency and busy gating
 */

`include "exu_params.svh"

module exu_tb
	import exu_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_LOGIC = 60;
	localparam int N_ARITH = 60;
	localparam int N_CMP   = 40;
	localparam int N_MUL   = 20;
	localparam int N_DIV   = 30;
	// requests per section with HI/LO reads and dropped strobes
	localparam int N_REQ = N_LOGIC + N_ARITH + N_CMP + 11 * N_MUL + 5 * (N_DIV + 6) + 2;
	// a divide holds the unit for at most 34 cycles
	localparam int CYCLE_LIMIT  = N_REQ * 36 + 100;
	localparam int DIV_WAIT_MAX = 40;

	logic       clk;
	logic       arst_n_i;
	logic       req_valid_i;
	exu_req_t   req_i;
	logic       wb_valid_o;
	exu_wb_t    wb_o;
	logic       busy_o;

	integer     seed = 96;
	int         cyc;
	int         val_errs;
	int         proto_errs;
	exu_hilo_t  model_hilo;
	// expected writebacks and their issue cycles in issue order
	exu_wb_t    exp_q [$];
	int         exp_cyc_q [$];

	exu_top i_exu_top
	(
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.wb_valid_o  (wb_valid_o),
		.wb_o        (wb_o),
		.busy_o      (busy_o)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	initial
	begin
		wait (cyc >= CYCLE_LIMIT);
		$display("timeout: run stopped after %0d cycles", cyc);
		$display("TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [4:0] rand_reg();
		logic [31:0] r;
		r = $random(seed);
		return r[4:0];
	endfunction

	// bias toward the sign boundary
	function automatic logic [31:0] edge_word();
		case (rand_below(8))
			0: return 32'h7fff_ffff;
			1: return 32'h8000_0000;
			2: return 32'hffff_ffff;
			3: return 32'h0000_0000;
			4: return 32'h0000_0001;
			default: return rand_word();
		endcase
	endfunction

	// run of equal bits from the top
	function automatic int count_lead(input logic [31:0] v, input logic bit_val);
		int n;
		n = 0;
		while (n < 32 && v[31 - n] == bit_val)
			n++;
		return n;
	endfunction

	function automatic bit writes_gpr(input exu_op_e op);
		return !(op == OP_NOP || op == OP_DIV || op == OP_DIVU || op == OP_MULT ||
			op == OP_MULTU || op == OP_MTHI || op == OP_MTLO);
	endfunction

	function automatic exu_wb_t expected_wb(input exu_req_t r);
		exu_wb_t      w;
		logic [4:0]   sh;
		logic [32:0]  s;
		logic [63:0]  p;
		w.rd   = r.rd;
		w.we   = 1'b1;
		w.data = '0;
		// immediate shifts read the sa field and variable shifts the low bits
		if (r.op == OP_SLL || r.op == OP_SRL || r.op == OP_SRA)
			sh = r.opa[`EXU_SA_LSB +: 5];
		else
			sh = r.opa[4:0];
		// one extra sign bit exposes signed overflow
		if (r.op == OP_SUB || r.op == OP_SUBU)
			s = {r.opa[31], r.opa} - {r.opb[31], r.opb};
		else
			s = {r.opa[31], r.opa} + {r.opb[31], r.opb};
		p = {{32{r.opa[31]}}, r.opa} * {{32{r.opb[31]}}, r.opb};
		case (r.op)
			OP_OR:           w.data = r.opa | r.opb;
			OP_AND:          w.data = r.opa & r.opb;
			OP_XOR:          w.data = r.opa ^ r.opb;
			OP_NOR:          w.data = ~(r.opa | r.opb);
			OP_LUI:          w.data = {r.opb[15:0], 16'h0000};
			OP_SLL, OP_SLLV: w.data = r.opb << sh;
			OP_SRL, OP_SRLV: w.data = r.opb >> sh;
			// logical shift plus sign fill of the vacated bits
			OP_SRA, OP_SRAV: w.data = (r.opb >> sh) | ({32{r.opb[31]}} & ~(32'hffff_ffff >> sh));
			OP_ADD, OP_ADDU, OP_SUB, OP_SUBU:
			begin
				w.data = s[31:0];
				if (r.op == OP_ADD || r.op == OP_SUB)
					w.we = (s[32] == s[31]);
			end
			OP_SLT:          w.data = {31'd0, $signed(r.opa) < $signed(r.opb)};
			OP_SLTU:         w.data = {31'd0, r.opa < r.opb};
			OP_CLZ:          w.data = count_lead(r.opa, 1'b0);
			OP_CLO:          w.data = count_lead(r.opa, 1'b1);
			OP_MOV:          w.data = r.opa;
			OP_MFHI:         w.data = model_hilo.hi;
			OP_MFLO:         w.data = model_hilo.lo;
			OP_MUL:          w.data = p[31:0];
			default:         w.data = '0;
		endcase
		return w;
	endfunction

	function automatic exu_hilo_t expected_div(input exu_req_t r);
		exu_hilo_t           h;
		logic signed [63:0]  a;
		logic signed [63:0]  b;
		logic signed [63:0]  q;
		logic signed [63:0]  m;
		a = (r.op == OP_DIV) ? {{32{r.opa[31]}}, r.opa} : {32'd0, r.opa};
		b = (r.op == OP_DIV) ? {{32{r.opb[31]}}, r.opb} : {32'd0, r.opb};
		if (r.opb == '0)
		begin
			h.hi = r.opa;
			h.lo = '1;
		end
		else
		begin
			// truncates toward zero and the remainder keeps the dividend sign
			q = a / b;
			m = a % b;
			h.hi = m[31:0];
			h.lo = q[31:0];
		end
		return h;
	endfunction

	// leading zeros of the divisor magnitude plus two
	function automatic int div_cycles(input exu_op_e op, input logic [31:0] b);
		logic [31:0] mag;
		mag = (op == OP_DIV && b[31]) ? -b : b;
		return count_lead(mag, 1'b0) + 2;
	endfunction

	task automatic update_model(input exu_req_t r);
		case (r.op)
			OP_MULT:         model_hilo = {{32{r.opa[31]}}, r.opa} * {{32{r.opb[31]}}, r.opb};
			OP_MULTU:        model_hilo = {32'd0, r.opa} * {32'd0, r.opb};
			OP_MTHI:         model_hilo.hi = r.opa;
			OP_MTLO:         model_hilo.lo = r.opa;
			OP_DIV, OP_DIVU: model_hilo = expected_div(r);
			default:         ;
		endcase
	endtask

	task automatic check_wb(input exu_wb_t got, input exu_wb_t exp);
		if (got !== exp)
		begin
			val_errs++;
			$display("FAILED %0t: wb rd %0d we %0b data %h, expected rd %0d we %0b data %h",
				$time, got.rd, got.we, got.data, exp.rd, exp.we, exp.data);
		end
	endtask

	task automatic check_hilo(input exu_hilo_t got, input exu_hilo_t exp);
		if (got !== exp)
		begin
			val_errs++;
			$display("FAILED %0t: hi %h lo %h, expected hi %h lo %h",
				$time, got.hi, got.lo, exp.hi, exp.lo);
		end
	endtask

	task automatic check_busy_cycles(input int got, input int exp);
		if (got != exp)
		begin
			val_errs++;
			$display("FAILED %0t: busy_o high for %0d cycles, expected %0d", $time, got, exp);
		end
	endtask

	// a writeback strobe is due one cycle after issue
	always @(negedge clk)
	begin : wb_monitor
		exu_wb_t  e;
		int       c;
		if (wb_valid_o)
		begin
			if (exp_q.size() == 0 || exp_cyc_q[0] >= cyc)
			begin
				proto_errs++;
				$display("unexpected writeback strobe at %0t for rd %0d", $time, wb_o.rd);
			end
			else
			begin
				e = exp_q.pop_front();
				c = exp_cyc_q.pop_front();
				check_wb(wb_o, e);
			end
		end
		else if (exp_q.size() != 0 && cyc > exp_cyc_q[0])
		begin
			proto_errs++;
			$display("writeback strobe missing at %0t for rd %0d", $time, exp_q[0].rd);
			e = exp_q.pop_front();
			c = exp_cyc_q.pop_front();
		end
	end

	task automatic issue(input exu_op_e op, input logic [31:0] a, input logic [31:0] b,
		input logic [4:0] rd);
		exu_req_t r;
		r.op  = op;
		r.opa = a;
		r.opb = b;
		r.rd  = rd;
		@(negedge clk);
		req_valid_i = 1'b1;
		req_i       = r;
		if (writes_gpr(op))
		begin
			exp_q.push_back(expected_wb(r));
			exp_cyc_q.push_back(cyc);
		end
		update_model(r);
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(negedge clk);
			req_valid_i = 1'b0;
		end
	endtask

	// MFHI then MFLO back to back with data sampled one cycle after each
	task automatic read_back_hilo();
		exu_hilo_t got;
		exu_hilo_t exp;
		exp = model_hilo;
		issue(OP_MFHI, rand_word(), rand_word(), rand_reg());
		issue(OP_MFLO, rand_word(), rand_word(), rand_reg());
		got.hi = wb_o.data;
		idle(1);
		got.lo = wb_o.data;
		check_hilo(got, exp);
	endtask

	task automatic run_div(input exu_op_e op, input logic [31:0] a, input logic [31:0] b,
		input bit inject);
		int n;
		int len;
		n   = 0;
		len = div_cycles(op, b);
		issue(op, a, b, rand_reg());
		@(negedge clk);
		req_valid_i = 1'b0;
		while (busy_o && n < DIV_WAIT_MAX)
		begin
			// a restarted divide would stretch busy and an ADD would strobe
			if (inject && n < 2)
			begin
				req_valid_i = 1'b1;
				req_i.op    = (n == 0) ? OP_DIVU : OP_ADD;
				req_i.opa   = rand_word();
				req_i.opb   = rand_word();
				req_i.rd    = rand_reg();
			end
			else
				req_valid_i = 1'b0;
			n++;
			@(negedge clk);
		end
		req_valid_i = 1'b0;
		if (busy_o)
		begin
			proto_errs++;
			$display("busy_o stuck high after a divide at %0t", $time);
		end
		else
			check_busy_cycles(n, len);
		read_back_hilo();
	endtask

	initial
	begin
		logic [31:0] a;
		logic [31:0] b;
		arst_n_i    = 1'b0;
		req_valid_i = 1'b0;
		req_i       = '0;
		model_hilo  = '0;
		val_errs    = 0;
		proto_errs  = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n_i = 1'b1;

		// quiet after reset with HI/LO cleared
		repeat (4)
		begin
			@(negedge clk);
			if (busy_o)
			begin
				proto_errs++;
				$display("busy_o high after reset at %0t", $time);
			end
		end
		read_back_hilo();

		// logic, lui and the six shifts issued back to back
		repeat (N_LOGIC)
			issue(exu_op_e'(int'(OP_OR) + rand_below(11)), rand_word(), rand_word(), rand_reg());
		idle(2);

		repeat (N_ARITH)
			issue(exu_op_e'(int'(OP_ADD) + rand_below(4)), edge_word(), edge_word(), rand_reg());
		idle(2);

		// shifted words spread the leading counts over 0 to 32
		repeat (N_CMP)
		begin
			a = rand_word() >> rand_below(33);
			if (rand_below(2))
				a = ~a;
			if (rand_below(4) == 0)
				a = edge_word();
			issue(exu_op_e'(int'(OP_SLT) + rand_below(4)), a, edge_word(), rand_reg());
		end
		idle(2);

		repeat (N_MUL)
		begin
			issue(OP_MUL, edge_word(), rand_word(), rand_reg());
			issue(rand_below(2) ? OP_MULT : OP_MULTU, edge_word(), rand_word(), rand_reg());
			read_back_hilo();
			issue(OP_MTHI, rand_word(), rand_word(), rand_reg());
			read_back_hilo();
			issue(OP_MTLO, rand_word(), rand_word(), rand_reg());
			read_back_hilo();
			issue(OP_MOV, rand_word(), rand_word(), rand_reg());
		end
		idle(2);

		// sign corners, the overflow quotient and zero divisors
		run_div(OP_DIV, 32'hffff_fff9, 32'd2, 1'b0);
		run_div(OP_DIV, 32'd7, 32'hffff_fffe, 1'b0);
		run_div(OP_DIV, 32'h8000_0000, 32'hffff_ffff, 1'b0);
		run_div(OP_DIVU, 32'h1234_5678, 32'd0, 1'b0);
		run_div(OP_DIV, 32'hffff_ff00, 32'd0, 1'b0);
		// small divisor gives a long busy window for the dropped strobes
		run_div(OP_DIVU, rand_word(), 32'd3, 1'b1);
		repeat (N_DIV)
		begin
			b = (rand_below(6) == 0) ? 32'd0 : rand_word() >> rand_below(32);
			if (rand_below(2))
				b = -b;
			run_div(rand_below(2) ? OP_DIV : OP_DIVU, edge_word(), b, rand_below(5) == 0);
		end

		idle(4);
		if (exp_q.size() != 0)
		begin
			proto_errs += exp_q.size();
			$display("%0d expected writebacks never arrived", exp_q.size());
		end
		$display("errors: %0d value, %0d protocol", val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- exu_params.svh
/*
 * execute unit widths and constants
 * shared by the package and the RTL modules
 */

`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// data word width
`define EXU_XLEN 32

// gpr address width
`define EXU_REG_AW 5

// operation code width, room for every kept op
`define EXU_OP_W 5

// sa field of an immediate shift sits in operand a
// starting at this bit
`define EXU_SA_LSB 6

// divider count width, holds a leading-zero count up to 32
`define EXU_CNT_W 6

// divider count value meaning no divide in flight
// never reached by a real count (max is 32)
`define EXU_DIV_IDLE {`EXU_CNT_W{1'b1}}

`endif

//--- rtl/exu_alu.sv
/*
 * single-cycle execute datapath: logic, shift, move, add/sub, compare,
 * count and multiply, with registered gpr and HI/LO write outputs
 */

`include "exu_params.svh"

module exu_alu
	import exu_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n_i,
	input  logic          req_valid_i,
	input  exu_req_t      req_i,
	input  exu_hilo_t     hilo_i,
	output logic          wb_valid_o,
	output exu_wb_t       wb_o,
	output exu_hilo_wr_t  hilo_wr_o
);

	localparam int XLEN = `EXU_XLEN;
	localparam int SHW  = $clog2(`EXU_XLEN);

	exu_op_e             op;
	logic [XLEN-1:0]     opa;
	logic [XLEN-1:0]     opb;

	// per-class results
	logic [XLEN-1:0]     logic_res;
	logic [XLEN-1:0]     shift_res;
	logic [XLEN-1:0]     move_res;
	logic [XLEN-1:0]     math_res;

	logic [SHW-1:0]      sa;
	logic [SHW-1:0]      sv;

	logic                sub;
	logic [XLEN-1:0]     opb_mux;
	logic [XLEN-1:0]     sum;
	logic                ovf;
	logic                lt;
	logic [`EXU_CNT_W-1:0] lead_cnt;

	logic                mul_signed;
	logic [XLEN-1:0]     mul_a;
	logic [XLEN-1:0]     mul_b;
	logic [2*XLEN-1:0]   mul_mag;
	logic [2*XLEN-1:0]   mul_res;

	logic                gpr_op;
	logic                hilo_op;
	logic [XLEN-1:0]     wb_data;
	exu_wb_t             wb_d;
	exu_hilo_t           hilo_cur;
	exu_hilo_t           hilo_nx;
	logic                hilo_we_q;
	exu_hilo_t           hilo_q;

	assign op  = req_i.op;
	assign opa = req_i.opa;
	assign opb = req_i.opb;

	// pending write from last cycle not yet in the HI/LO regs
	assign hilo_cur = hilo_we_q ? hilo_q : hilo_i;

	always_comb
	begin
		case (op)
			OP_OR:   logic_res = opa | opb;
			OP_AND:  logic_res = opa & opb;
			OP_XOR:  logic_res = opa ^ opb;
			OP_NOR:  logic_res = ~(opa | opb);
			OP_LUI:  logic_res = {opb[XLEN/2-1:0], {(XLEN/2){1'b0}}};
			default: logic_res = '0;
		endcase
	end

	// value in opb, amount in opa
	assign sa = opa[`EXU_SA_LSB +: SHW];
	assign sv = opa[SHW-1:0];

	always_comb
	begin
		case (op)
			OP_SLL:  shift_res = opb << sa;
			OP_SRL:  shift_res = opb >> sa;
			OP_SRA:  shift_res = $signed(opb) >>> sa;
			OP_SLLV: shift_res = opb << sv;
			OP_SRLV: shift_res = opb >> sv;
			OP_SRAV: shift_res = $signed(opb) >>> sv;
			default: shift_res = '0;
		endcase
	end

	always_comb
	begin
		case (op)
			// movn/movz condition is settled before issue
			OP_MOV:  move_res = opa;
			OP_MFHI: move_res = hilo_cur.hi;
			OP_MFLO: move_res = hilo_cur.lo;
			default: move_res = '0;
		endcase
	end

	// a - b as a + ~b + 1, slt reuses the difference
	assign sub     = (op == OP_SUB) || (op == OP_SUBU) || (op == OP_SLT);
	assign opb_mux = sub ? ~opb + 1'b1 : opb;
	assign sum     = opa + opb_mux;

	// overflow when the result sign breaks from operand signs
	assign ovf = sub ? (opa[XLEN-1] != opb[XLEN-1]) && (sum[XLEN-1] != opa[XLEN-1])
			 : (opa[XLEN-1] == opb[XLEN-1]) && (sum[XLEN-1] != opa[XLEN-1]);

	// differing signs decide directly, else the difference sign
	assign lt = (op == OP_SLT) ?
			((opa[XLEN-1] != opb[XLEN-1]) ? opa[XLEN-1] : sum[XLEN-1]) :
			(opa < opb);

	// clo counts zeros of the inverted word
	assign lead_cnt = exu_clz((op == OP_CLO) ? ~opa : opa);

	// sign-magnitude multiply
	assign mul_signed = (op == OP_MUL) || (op == OP_MULT);
	assign mul_a      = (mul_signed && opa[XLEN-1]) ? -opa : opa;
	assign mul_b      = (mul_signed && opb[XLEN-1]) ? -opb : opb;
	assign mul_mag    = mul_a * mul_b;
	assign mul_res    = (mul_signed && (opa[XLEN-1] ^ opb[XLEN-1])) ? -mul_mag : mul_mag;

	always_comb
	begin
		case (op)
			OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: math_res = sum;
			OP_SLT, OP_SLTU:                  math_res = {{(XLEN-1){1'b0}}, lt};
			OP_CLZ, OP_CLO:                   math_res = {{(XLEN-`EXU_CNT_W){1'b0}}, lead_cnt};
			OP_MUL:                           math_res = mul_res[XLEN-1:0];
			default:                          math_res = '0;
		endcase
	end

	// pick the class and decide which write the op makes
	always_comb
	begin
		gpr_op  = 1'b1;
		hilo_op = 1'b0;
		case (op)
			OP_OR, OP_AND, OP_XOR, OP_NOR, OP_LUI:
				wb_data = logic_res;
			OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV:
				wb_data = shift_res;
			OP_MOV, OP_MFHI, OP_MFLO:
				wb_data = move_res;
			OP_MTHI, OP_MTLO, OP_MULT, OP_MULTU:
			begin
				wb_data = '0;
				gpr_op  = 1'b0;
				hilo_op = 1'b1;
			end
			// nop and divides never reach a gpr from here
			OP_NOP, OP_DIV, OP_DIVU:
			begin
				wb_data = '0;
				gpr_op  = 1'b0;
			end
			default:
				wb_data = math_res;
		endcase
	end

	assign wb_d.rd   = req_i.rd;
	assign wb_d.we   = !(ovf && ((op == OP_ADD) || (op == OP_SUB)));
	assign wb_d.data = wb_data;

	// mthi/mtlo refill the other half from current HI/LO
	always_comb
	begin
		case (op)
			OP_MTHI: hilo_nx = '{hi: opa, lo: hilo_cur.lo};
			OP_MTLO: hilo_nx = '{hi: hilo_cur.hi, lo: opa};
			default: hilo_nx = mul_res;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			wb_valid_o <= 1'b0;
			hilo_we_q  <= 1'b0;
		end
		else
		begin
			wb_valid_o <= req_valid_i && gpr_op;
			hilo_we_q  <= req_valid_i && hilo_op;
		end
	end

	always_ff @(posedge clk)
	begin
		if (req_valid_i && gpr_op)
			wb_o <= wb_d;
		if (req_valid_i && hilo_op)
			hilo_q <= hilo_nx;
	end

	assign hilo_wr_o.we   = hilo_we_q;
	assign hilo_wr_o.hilo = hilo_q;

endmodule

//--- rtl/exu_div.sv
/*
 * multi-cycle shift-subtract divider, signed and unsigned,
 * iteration count set by the divisor's leading zeros
 */

`include "exu_params.svh"

module exu_div
	import exu_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n_i,
	input  logic          start_i,
	input  exu_req_t      req_i,
	output logic          busy_o,
	output exu_hilo_wr_t  hilo_wr_o
);

	localparam int XLEN = `EXU_XLEN;

	logic                   is_signed;
	logic [XLEN-1:0]        a_mag;
	logic [XLEN-1:0]        b_mag;

	logic [`EXU_CNT_W-1:0]  cnt_q;
	logic                   running;
	logic                   last;
	logic                   wr_we_q;
	exu_hilo_t              wr_hilo_q;

	// partial remainder, quotient, divisor magnitude
	logic [XLEN-1:0]        rem_q;
	logic [XLEN-1:0]        quo_q;
	logic [XLEN-1:0]        dsr_q;
	logic                   q_neg_q;
	logic                   r_neg_q;
	logic                   dz_q;

	logic [XLEN-1:0]        dsr_sh;
	logic [XLEN-1:0]        rem_d;
	logic [XLEN-1:0]        quo_d;

	// div works on magnitudes, divu takes operands as they are
	assign is_signed = (req_i.op == OP_DIV);
	assign a_mag     = (is_signed && req_i.opa[XLEN-1]) ? -req_i.opa : req_i.opa;
	assign b_mag     = (is_signed && req_i.opb[XLEN-1]) ? -req_i.opb : req_i.opb;

	assign running = (cnt_q != `EXU_DIV_IDLE);
	assign last    = running && (cnt_q == '0);

	// busy also covers the cycle the result write is presented
	assign busy_o = running || wr_we_q;

	// divisor aligned to the current quotient bit
	// clz start keeps it inside the word, zero divisor stays zero
	assign dsr_sh = dsr_q << cnt_q;

	always_comb
	begin
		rem_d = rem_q;
		quo_d = quo_q;
		if (rem_q >= dsr_sh)
		begin
			rem_d = rem_q - dsr_sh;
			// count 32 on a zero divisor sets no bit
			quo_d = quo_q | ({{(XLEN-1){1'b0}}, 1'b1} << cnt_q);
		end
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			cnt_q   <= `EXU_DIV_IDLE;
			wr_we_q <= 1'b0;
		end
		else
		begin
			wr_we_q <= last;
			if (start_i)
				cnt_q <= exu_clz(b_mag);
			else if (last)
				cnt_q <= `EXU_DIV_IDLE;
			else if (running)
				cnt_q <= cnt_q - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (start_i)
		begin
			rem_q   <= a_mag;
			quo_q   <= '0;
			dsr_q   <= b_mag;
			// quotient negative on differing signs, remainder follows dividend
			q_neg_q <= is_signed && (req_i.opa[XLEN-1] ^ req_i.opb[XLEN-1]);
			r_neg_q <= is_signed && req_i.opa[XLEN-1];
			dz_q    <= (req_i.opb == '0);
		end
		else if (running)
		begin
			rem_q <= rem_d;
			quo_q <= quo_d;
		end

		// final step, restore signs into the HI/LO write
		if (last)
		begin
			wr_hilo_q.hi <= r_neg_q ? -rem_d : rem_d;
			wr_hilo_q.lo <= dz_q ? '1 : (q_neg_q ? -quo_d : quo_d);
		end
	end

	assign hilo_wr_o.we   = wr_we_q;
	assign hilo_wr_o.hilo = wr_hilo_q;

endmodule

//--- rtl/exu_hilo.sv
/*
 * HI/LO register pair, divider write wins over the ALU write
 */

module exu_hilo
	import exu_pkg::*;
(
	input  logic          clk,
	input  logic          arst_n_i,
	input  exu_hilo_wr_t  alu_wr_i,
	input  exu_hilo_wr_t  div_wr_i,
	output exu_hilo_t     hilo_o
);

	exu_hilo_t hilo_q;

	// architectural state, zero after reset
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			hilo_q <= '0;
		end
		else if (div_wr_i.we)
		begin
			// quotient in lo, remainder in hi
			hilo_q <= div_wr_i.hilo;
		end
		else if (alu_wr_i.we)
		begin
			// mult/multu product or mthi/mtlo pair
			hilo_q <= alu_wr_i.hilo;
		end
	end

	// read by mfhi/mflo and by the mthi/mtlo refill
	assign hilo_o = hilo_q;

endmodule

//--- rtl/exu_pkg.sv
/*
 * execute unit types, operation codes and the shared leading-zero count
 */

`include "exu_params.svh"

package exu_pkg;

	// one code per kept operation
	// immediate forms share the register form code
	typedef enum logic [`EXU_OP_W-1:0]
	{
		OP_NOP, OP_OR, OP_AND, OP_XOR, OP_NOR, OP_LUI,
		OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
		OP_CLZ, OP_CLO, OP_MOV, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
		OP_MUL, OP_MULT, OP_MULTU, OP_DIV, OP_DIVU
	} exu_op_e;

	// issue request, operand b already carries any immediate
	typedef struct packed
	{
		exu_op_e                 op;
		logic [`EXU_XLEN-1:0]    opa;
		logic [`EXU_XLEN-1:0]    opb;
		logic [`EXU_REG_AW-1:0]  rd;
	} exu_req_t;

	// gpr write, we low drops the write (signed overflow)
	typedef struct packed
	{
		logic [`EXU_REG_AW-1:0]  rd;
		logic                    we;
		logic [`EXU_XLEN-1:0]    data;
	} exu_wb_t;

	typedef struct packed
	{
		logic [`EXU_XLEN-1:0]    hi;
		logic [`EXU_XLEN-1:0]    lo;
	} exu_hilo_t;

	typedef struct packed
	{
		logic       we;
		exu_hilo_t  hilo;
	} exu_hilo_wr_t;

	// leading zeros of a word, 32 when all zero
	function automatic logic [`EXU_CNT_W-1:0] exu_clz(input logic [`EXU_XLEN-1:0] v);
		logic [`EXU_CNT_W-1:0] n;
		logic                  hit;
		n = '0;
		hit = 1'b0;
		for (int i = `EXU_XLEN - 1; i >= 0; i--)
		begin
			if (v[i])
				hit = 1'b1;
			else if (!hit)
				n = n + 1'b1;
		end
		return n;
	endfunction

endpackage

//--- rtl/exu_top.sv
/*
 * execute unit top: issue gating, ALU, divider and HI/LO storage
 */

module exu_top
	import exu_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n_i,
	input  logic      req_valid_i,
	input  exu_req_t  req_i,
	output logic      wb_valid_o,
	output exu_wb_t   wb_o,
	output logic      busy_o
);

	logic          accept;
	logic          is_div;
	exu_hilo_t     hilo;
	exu_hilo_wr_t  alu_hilo_wr;
	exu_hilo_wr_t  div_hilo_wr;

	// strobes during a divide are dropped
	assign accept = req_valid_i && !busy_o;
	assign is_div = (req_i.op == OP_DIV) || (req_i.op == OP_DIVU);

	exu_alu i_exu_alu
	(
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.req_valid_i (accept && !is_div),
		.req_i       (req_i),
		.hilo_i      (hilo),
		.wb_valid_o  (wb_valid_o),
		.wb_o        (wb_o),
		.hilo_wr_o   (alu_hilo_wr)
	);

	// busy comes straight from the divider
	exu_div i_exu_div
	(
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.start_i    (accept && is_div),
		.req_i      (req_i),
		.busy_o     (busy_o),
		.hilo_wr_o  (div_hilo_wr)
	);

	exu_hilo i_exu_hilo
	(
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.alu_wr_i  (alu_hilo_wr),
		.div_wr_i  (div_hilo_wr),
		.hilo_o    (hilo)
	);

endmodule
